// ==== Makefile ====
# Verilator build and run of the multiply unit testbench
# the FAST or SLOW datapath is chosen by MUL_SPEED in include/mul_settings.svh
VERILATOR ?= verilator
TOP ?= mulLiteTb
FLIST ?= mulLiteTop.f
OBJ_DIR ?= obj_dir
VFLAGS ?= -j 0
SIM_ARGS ?=

BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(FLIST) $(wildcard include/*.svh src/*.sv dv/*.sv)

.PHONY: test clean help

test: $(BIN)
	@out="$$($(BIN) $(SIM_ARGS) 2>&1)"; echo "$$out"; echo "$$out" | grep -q "TESTS PASSED"

$(BIN): $(SOURCES)
	$(VERILATOR) --binary --assert --top-module $(TOP) -Mdir $(OBJ_DIR) $(VFLAGS) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)

help:
	@echo "targets: test (build and run, default), clean (remove $(OBJ_DIR)), help"
	@echo "variables: VERILATOR TOP FLIST OBJ_DIR VFLAGS SIM_ARGS"

// ==== dv/mulLiteTb.sv ====
// testbench top, drives the multiply unit over AXI4-Lite and checks it against a product model
`timescale 1ns/1ps
`default_nettype none
`include "mul_settings.svh"

module mulLiteTb;

	localparam int timeoutCycles = 100;
	localparam logic [1:0] respOkay = 2'b00; // AXI response encodings
	localparam logic [1:0] respSlverr = 2'b10;

	logic clk;
	logic rst;
	lauPkg::axilReqT axilReq;
	lauPkg::axilRspT axilRsp;
	integer seed;

	tbClockGen clkGen0 (
		.clk(clk),
		.rst(rst)
	);

	mulLiteTop dut0 (
		.clk(clk),
		.rst(rst),
		.axilReq(axilReq),
		.axilRsp(axilRsp)
	);

	task automatic abortOnTimeout(input string what);
		$display("timeout: no %s within %0d cycles", what, timeoutCycles);
		$display("TESTS FAILED");
		$fatal(1, "timeout");
	endtask

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("ERROR %s expected 0x%0h actual 0x%0h", name, expected, actual);
			$display("TESTS FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	// plain widened product of the masked operands
	function automatic logic [`MUL_WIDTH_P-1:0] refProduct(input logic [`MUL_WIDTH_X-1:0] x,
		input logic [`MUL_WIDTH_Y-1:0] y);
		logic [`MUL_WIDTH_P-1:0] wideX;
		logic [`MUL_WIDTH_P-1:0] wideY;
		wideX = '0;
		wideY = '0;
		wideX[`MUL_WIDTH_X-1:0] = x;
		wideY[`MUL_WIDTH_Y-1:0] = y;
		return wideX * wideY;
	endfunction

	// ready and valid are sampled on the falling edge, where they are stable
	task automatic waitWriteReady();
		int cycles;
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
			if (cycles > timeoutCycles) abortOnTimeout("awready and wready");
		end while (!(axilRsp.awready && axilRsp.wready));
	endtask

	task automatic waitWriteResp();
		int cycles;
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
			if (cycles > timeoutCycles) abortOnTimeout("bvalid");
		end while (!axilRsp.b.valid);
	endtask

	task automatic waitReadReady();
		int cycles;
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
			if (cycles > timeoutCycles) abortOnTimeout("arready");
		end while (!axilRsp.arready);
	endtask

	task automatic waitReadData();
		int cycles;
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
			if (cycles > timeoutCycles) abortOnTimeout("rvalid");
		end while (!axilRsp.r.valid);
	endtask

	task automatic axilWrite(input logic [`AXIL_ADDR_WIDTH-1:0] addr, input logic [31:0] data,
		input logic [3:0] strb, output logic [1:0] resp);
		@(posedge clk);
		axilReq.aw.addr <= addr;
		axilReq.aw.valid <= 1'b1;
		axilReq.w.data <= data;
		axilReq.w.strb <= strb;
		axilReq.w.valid <= 1'b1;
		waitWriteReady();
		@(posedge clk); // aw and w transfer here
		axilReq.aw.valid <= 1'b0;
		axilReq.w.valid <= 1'b0;
		waitWriteResp();
		resp = axilRsp.b.resp;
		@(posedge clk); // b handshake, bready high
	endtask

	task automatic axilRead(input logic [`AXIL_ADDR_WIDTH-1:0] addr, output logic [31:0] data,
		output logic [1:0] resp);
		@(posedge clk);
		axilReq.ar.addr <= addr;
		axilReq.ar.valid <= 1'b1;
		waitReadReady();
		@(posedge clk);
		axilReq.ar.valid <= 1'b0;
		waitReadData();
		data = axilRsp.r.data;
		resp = axilRsp.r.resp;
		@(posedge clk); // r handshake
	endtask

	// reads status until busy drops, then done has to be up
	task automatic pollUntilIdle(input string name);
		int polls;
		logic [31:0] status;
		logic [1:0] resp;
		polls = 0;
		do begin
			axilRead(`REG_STATUS, status, resp);
			polls++;
			if (polls > timeoutCycles) abortOnTimeout("idle status");
		end while (status[0]);
		checkValue({name, " done"}, 32'd1, 32'(status[1]));
	endtask

	task automatic startAndWait(input string name);
		logic [1:0] resp;
		logic [31:0] status;
		axilWrite(`REG_CTRL, 32'd1, 4'hF, resp);
		axilRead(`REG_STATUS, status, resp); // right after the b handshake
		checkValue({name, " done after start"}, 32'd0, 32'(status[1]));
		pollUntilIdle(name);
	endtask

	task automatic runProduct(input string name, input logic [31:0] xw, input logic [31:0] yw);
		logic [`MUL_WIDTH_P-1:0] expected;
		logic [31:0] data;
		logic [1:0] resp;
		expected = refProduct(xw[`MUL_WIDTH_X-1:0], yw[`MUL_WIDTH_Y-1:0]);
		axilWrite(`REG_X, xw, 4'hF, resp);
		axilWrite(`REG_Y, yw, 4'hF, resp);
		startAndWait(name);
		axilRead(`REG_PLO, data, resp);
		checkValue({name, " plo"}, expected[31:0], data);
		axilRead(`REG_PHI, data, resp);
		checkValue({name, " phi"}, 32'(expected >> 32), data); // zero-extended top
	endtask

	initial begin
		logic [1:0] resp;
		logic [31:0] data;
		logic [31:0] held;
		logic [31:0] xw;
		logic [31:0] yw;
		logic [`MUL_WIDTH_P-1:0] expected;
		int cycles;

		seed = 50;
		axilReq <= '0;
		axilReq.bready <= 1'b1; // both ready by default
		axilReq.rready <= 1'b1;
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
			if (cycles > timeoutCycles) abortOnTimeout("reset release");
		end while (rst);

		// every mapped register zero after reset, OKAY
		for (int a = 0; a < 6; a++) begin
			axilRead(`AXIL_ADDR_WIDTH'(4*a), data, resp);
			checkValue($sformatf("reset value 0x%0h", 4*a), 32'd0, data);
			checkValue($sformatf("reset resp 0x%0h", 4*a), 32'(respOkay), 32'(resp));
		end

		axilWrite('h40, 32'hDEAD_BEEF, 4'hF, resp);
		checkValue("unmapped write resp", 32'(respSlverr), 32'(resp));
		axilRead('h40, data, resp);
		checkValue("unmapped read resp", 32'(respSlverr), 32'(resp));
		checkValue("unmapped read data", 32'd0, data);

		// readback masked to operand widths, then byte strobes
		axilWrite(`REG_X, 32'hFFFF_ABCD, 4'hF, resp);
		checkValue("x write resp", 32'(respOkay), 32'(resp));
		axilWrite(`REG_Y, 32'hA512_3456, 4'hF, resp);
		axilRead(`REG_X, data, resp);
		checkValue("x readback", 32'h0000_ABCD, data);
		axilRead(`REG_Y, data, resp);
		checkValue("y readback", 32'h0012_3456, data);
		axilWrite(`REG_X, 32'h5566_7711, 4'b0001, resp); // low byte only
		axilWrite(`REG_Y, 32'h5566_7788, 4'b0010, resp); // middle byte only
		axilRead(`REG_X, data, resp);
		checkValue("x strobe", 32'h0000_AB11, data);
		axilRead(`REG_Y, data, resp);
		checkValue("y strobe", 32'h0012_7756, data);

		runProduct("zero", 32'd0, 32'd0);
		runProduct("one", 32'd1, 32'd1);
		runProduct("all ones", 32'hFFFF_FFFF, 32'hFFFF_FFFF);
		runProduct("zero by ones", 32'd0, 32'hFFFF_FFFF);
		runProduct("ones by one", 32'hFFFF_FFFF, 32'd1);
		for (int i = 0; i < 200; i++) begin
			xw = $random(seed);
			yw = $random(seed);
			runProduct($sformatf("random %0d", i), xw, yw);
		end

		// second start without polling, only the second pair counts
		axilWrite(`REG_X, 32'h0000_BEEF, 4'hF, resp);
		axilWrite(`REG_Y, 32'h00C0_FFEE, 4'hF, resp);
		axilWrite(`REG_CTRL, 32'd1, 4'hF, resp);
		xw = $random(seed);
		yw = $random(seed);
		axilWrite(`REG_X, xw, 4'hF, resp);
		axilWrite(`REG_Y, yw, 4'hF, resp);
		axilWrite(`REG_CTRL, 32'd1, 4'hF, resp);
		pollUntilIdle("back to back");
		expected = refProduct(xw[`MUL_WIDTH_X-1:0], yw[`MUL_WIDTH_Y-1:0]);
		axilRead(`REG_PLO, data, resp);
		checkValue("back to back plo", expected[31:0], data);
		axilRead(`REG_PHI, data, resp);
		checkValue("back to back phi", 32'(expected >> 32), data);

		// rready held low for 10 cycles
		@(posedge clk);
		axilReq.rready <= 1'b0;
		axilReq.ar.addr <= `REG_PLO;
		axilReq.ar.valid <= 1'b1;
		waitReadReady();
		@(posedge clk);
		axilReq.ar.valid <= 1'b0;
		waitReadData();
		held = axilRsp.r.data;
		repeat (10) begin
			@(negedge clk);
			checkValue("r stall rvalid", 32'd1, 32'(axilRsp.r.valid));
			checkValue("r stall rdata", held, axilRsp.r.data);
		end
		@(posedge clk);
		axilReq.rready <= 1'b1;
		@(posedge clk); // r handshake
		@(negedge clk);
		checkValue("r stall released", 32'd0, 32'(axilRsp.r.valid));
		checkValue("r stall data", expected[31:0], held);

		// bready held low, second write queued behind the first
		@(posedge clk);
		axilReq.bready <= 1'b0;
		axilReq.aw.addr <= `REG_X;
		axilReq.aw.valid <= 1'b1;
		axilReq.w.data <= 32'h0000_1234;
		axilReq.w.strb <= 4'hF;
		axilReq.w.valid <= 1'b1;
		waitWriteReady();
		@(posedge clk); // first write taken, valids stay up
		axilReq.aw.addr <= `REG_Y;
		axilReq.w.data <= 32'h0056_789A;
		waitWriteResp();
		repeat (10) begin
			@(negedge clk);
			checkValue("b stall bvalid", 32'd1, 32'(axilRsp.b.valid));
			checkValue("b stall awready", 32'd0, 32'(axilRsp.awready));
		end
		@(posedge clk);
		axilReq.bready <= 1'b1;
		waitWriteReady();
		@(posedge clk);
		axilReq.aw.valid <= 1'b0;
		axilReq.w.valid <= 1'b0;
		waitWriteResp();
		@(posedge clk);
		axilRead(`REG_X, data, resp);
		checkValue("b stall first write", 32'h0000_1234, data);
		axilRead(`REG_Y, data, resp);
		checkValue("b stall second write", 32'h0056_789A, data);

		$display("TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== dv/tbClockGen.sv ====
// testbench clock of 8 ns period plus an active-high reset held for the first 5 cycles
`timescale 1ns/1ps
`default_nettype none

module tbClockGen #(
	parameter int halfPeriod = 4, // ns
	parameter int resetCycles = 5
) (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #halfPeriod clk = ~clk;
	end

	initial begin
		rst = 1'b1;
		repeat (resetCycles) @(posedge clk);
		rst <= 1'b0; // released on a rising edge like the other inputs
	end

endmodule

`default_nettype wire

// ==== include/mul_settings.svh ====
// widths, bus address width, speed choice and register map, included by the multiply unit sources
`ifndef MUL_SETTINGS_SVH
`define MUL_SETTINGS_SVH

`define MUL_WIDTH_X 16 // multiplier, keep <= multiplicand
`define MUL_WIDTH_Y 24 // multiplicand
`define MUL_WIDTH_P (`MUL_WIDTH_X + `MUL_WIDTH_Y) // full product
`define AXIL_ADDR_WIDTH 8
`define MUL_SPEED lauPkg::FAST // or lauPkg::SLOW

// byte offsets of the register map
`define REG_X 'h00
`define REG_Y 'h04
`define REG_CTRL 'h08 // bit 0 starts a multiplication
`define REG_STATUS 'h0C // bit 0 busy, bit 1 done
`define REG_PLO 'h10
`define REG_PHI 'h14

`endif

// ==== mulLiteTop.f ====
+incdir+include
src/lauPkg.sv
src/prefixAndOr.sv
src/prefixAdder.sv
src/cprSlice.sv
src/mopCsvAdder.sv
src/mulUns.sv
src/mulRegs.sv
src/mulLiteTop.sv
dv/tbClockGen.sv
dv/mulLiteTb.sv

// ==== src/cprSlice.sv ====
// one (m,2) compressor bit-slice of full adders, linear chain or tree, for the carry-save adder
`timescale 1ns/1ps
`default_nettype none

module cprSlice #(
	parameter int depth = 4, // bits of this weight
	parameter lauPkg::speedE speed = lauPkg::FAST
) (
	input wire logic [depth-1:0] A,
	input wire logic [depth-4:0] CI, // carries from the slice below
	output logic S,
	output logic C,
	output logic [depth-4:0] CO // carries to the slice above
);

	localparam int nFa = depth - 2; // full adders per slice

	// FIFO vector: input bits, then sum and carry-in in turn
	logic [3*depth-6:0] F;
	logic [nFa-1:0] faA;
	logic [nFa-1:0] faB;
	logic [nFa-1:0] faC;
	logic [nFa-1:0] faCo;

	assign F[depth-1:0] = A;

	// full adder cells, only the input wiring differs by speed
	for (genvar i = 0; i < nFa; i++) begin : gFa
		assign F[depth+2*i] = faA[i] ^ faB[i] ^ faC[i];
		assign faCo[i] = (faA[i] & faB[i]) | (faC[i] & (faA[i] ^ faB[i]));
		if (i < nFa-1) begin : gCin
			assign F[depth+2*i+1] = CI[i]; // queued behind its sum
		end
	end

	if (speed == lauPkg::SLOW) begin : gLinear
		for (genvar i = 0; i < nFa; i++) begin : gIn
			if (i == 0) begin : gFirst
				assign faA[i] = F[0];
				assign faB[i] = F[1];
				assign faC[i] = F[2];
			end else begin : gNext
				assign faA[i] = F[i+2]; // next fresh bit
				assign faB[i] = CI[i-1];
				assign faC[i] = F[depth+2*(i-1)]; // previous sum
			end
		end
	end else begin : gTree
		for (genvar i = 0; i < nFa; i++) begin : gIn
			assign faA[i] = F[3*i]; // take three from the head of the FIFO
			assign faB[i] = F[3*i+1];
			assign faC[i] = F[3*i+2];
		end
	end

	assign CO = faCo[nFa-2:0];
	assign S = F[3*depth-6]; // last sum written
	assign C = faCo[nFa-1];

endmodule

`default_nettype wire

// ==== src/lauPkg.sv ====
// shared types of the multiply unit, speed choice plus AXI4-Lite and multiplier structs
`default_nettype none
`include "mul_settings.svh"

package lauPkg;

	typedef enum logic {
		SLOW = 1'b0, // serial prefix, linear compressor
		FAST = 1'b1 // sklansky prefix, compressor tree
	} speedE;

	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	typedef struct packed {
		logic [`AXIL_ADDR_WIDTH-1:0] addr;
		logic valid;
	} axilAwT;

	typedef struct packed {
		logic [31:0] data;
		logic [3:0] strb; // one bit per byte lane
		logic valid;
	} axilWT;

	typedef struct packed {
		logic [1:0] resp;
		logic valid;
	} axilBT;

	typedef struct packed {
		logic [`AXIL_ADDR_WIDTH-1:0] addr;
		logic valid;
	} axilArT;

	typedef struct packed {
		logic [31:0] data;
		logic [1:0] resp;
		logic valid;
	} axilRT;

	// master side, all channels
	typedef struct packed {
		axilAwT aw;
		axilWT w;
		axilArT ar;
		logic bready;
		logic rready;
	} axilReqT;

	// slave side
	typedef struct packed {
		axilBT b;
		axilRT r;
		logic awready;
		logic wready;
		logic arready;
	} axilRspT;

	typedef struct packed {
		logic valid;
		logic [`MUL_WIDTH_X-1:0] x;
		logic [`MUL_WIDTH_Y-1:0] y;
	} mulReqT;

	typedef struct packed {
		logic valid;
		logic [`MUL_WIDTH_P-1:0] p;
	} mulRspT;

endpackage

`default_nettype wire

// ==== src/mopCsvAdder.sv ====
// multi-operand carry-save adder, one compressor slice per bit weight
`timescale 1ns/1ps
`default_nettype none

module mopCsvAdder #(
	parameter int width = 8,
	parameter int depth = 4, // operand count
	parameter lauPkg::speedE speed = lauPkg::FAST
) (
	input wire logic [depth*width-1:0] A, // operand k at [k*width +: width]
	output logic [width-1:0] S,
	output logic [width-1:0] C // already weighted, add to S
);

	logic [depth*width-1:0] byWeight; // all bits of weight i side by side
	logic [(depth-3)*(width+1)-1:0] carryChain; // slice-to-slice carries
	logic [width-1:0] carryT; // slice carries before shift

	for (genvar k = 0; k < depth; k++) begin : gOp
		for (genvar i = 0; i < width; i++) begin : gBit
			assign byWeight[i*depth+k] = A[k*width+i];
		end
	end

	assign carryChain[depth-4:0] = '0; // nothing below bit 0

	for (genvar i = 0; i < width; i++) begin : gSlice
		cprSlice #(
			.depth(depth),
			.speed(speed)
		) slice (
			.A(byWeight[i*depth +: depth]),
			.CI(carryChain[i*(depth-3) +: depth-3]),
			.S(S[i]),
			.C(carryT[i]),
			.CO(carryChain[(i+1)*(depth-3) +: depth-3])
		);
	end

	assign C = {carryT[width-2:0], 1'b0}; // top carry falls off the product width

endmodule

`default_nettype wire

// ==== src/mulLiteTop.sv ====
// multiply unit top, AXI4-Lite register file driving the pipelined multiplier
`timescale 1ns/1ps
`default_nettype none
`include "mul_settings.svh"

module mulLiteTop (
	input wire logic clk,
	input wire logic rst,
	input wire lauPkg::axilReqT axilReq,
	output lauPkg::axilRspT axilRsp
);

	lauPkg::mulReqT mulReq; // start pulse with operands
	lauPkg::mulRspT mulRsp; // product, 2 cycles later

	mulRegs regs0 (
		.clk(clk),
		.rst(rst),
		.axilReq(axilReq),
		.mulRsp(mulRsp),
		.axilRsp(axilRsp),
		.mulReq(mulReq)
	);

	mulUns #(
		.widthX(`MUL_WIDTH_X),
		.widthY(`MUL_WIDTH_Y),
		.speed(`MUL_SPEED)
	) mul0 (
		.clk(clk),
		.rst(rst),
		.mulReq(mulReq),
		.mulRsp(mulRsp)
	);

endmodule

`default_nettype wire

// ==== src/mulRegs.sv ====
// AXI4-Lite slave register file, operands, start and status, product capture
`timescale 1ns/1ps
`default_nettype none
`include "mul_settings.svh"

module mulRegs (
	input wire logic clk,
	input wire logic rst,
	input wire lauPkg::axilReqT axilReq,
	input wire lauPkg::mulRspT mulRsp,
	output lauPkg::axilRspT axilRsp,
	output lauPkg::mulReqT mulReq
);

	logic [`MUL_WIDTH_X-1:0] regX;
	logic [`MUL_WIDTH_Y-1:0] regY;
	logic [`MUL_WIDTH_P-1:0] regP; // last product
	logic startQ; // one-cycle request pulse
	logic [1:0] inFlight; // requests inside the multiplier
	logic done;
	logic busy;
	logic wrEn; // aw and w taken this cycle
	logic rdEn;
	logic startWr;
	logic [31:0] rdWord;
	lauPkg::axilBT bQ;
	lauPkg::axilRT rQ;

	function automatic logic isMapped(input logic [`AXIL_ADDR_WIDTH-1:0] addr);
		case (addr)
			`REG_X, `REG_Y, `REG_CTRL, `REG_STATUS, `REG_PLO, `REG_PHI: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	// both write channels together, stall while B is owed
	assign wrEn = axilReq.aw.valid & axilReq.w.valid & ~bQ.valid;
	assign rdEn = axilReq.ar.valid & ~rQ.valid;
	assign startWr = wrEn && (axilReq.aw.addr == `REG_CTRL)
		&& axilReq.w.strb[0] && axilReq.w.data[0];
	assign busy = startQ | (inFlight != 2'd0); // covers the pulse cycle too

	always_comb begin
		rdWord = 32'd0; // unmapped reads as zero
		case (axilReq.ar.addr)
			`REG_X: rdWord = 32'(regX);
			`REG_Y: rdWord = 32'(regY);
			`REG_STATUS: rdWord = {30'd0, done, busy};
			`REG_PLO: rdWord = regP[31:0];
			`REG_PHI: rdWord = 32'(regP[`MUL_WIDTH_P-1:32]); // zero-extended
			default: rdWord = 32'd0; // ctrl start bit self-clears
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			regX <= '0;
			regY <= '0;
			regP <= '0;
			startQ <= 1'b0;
			inFlight <= 2'd0;
			done <= 1'b0;
			bQ.valid <= 1'b0;
			rQ.valid <= 1'b0;
		end else begin
			if (wrEn && axilReq.aw.addr == `REG_X) begin
				for (int i = 0; i < `MUL_WIDTH_X; i++) begin
					if (axilReq.w.strb[i/8]) regX[i] <= axilReq.w.data[i]; // byte lanes
				end
			end
			if (wrEn && axilReq.aw.addr == `REG_Y) begin
				for (int i = 0; i < `MUL_WIDTH_Y; i++) begin
					if (axilReq.w.strb[i/8]) regY[i] <= axilReq.w.data[i];
				end
			end
			startQ <= startWr;
			if (startQ && !mulRsp.valid) begin
				inFlight <= inFlight + 2'd1;
			end else if (!startQ && mulRsp.valid) begin
				inFlight <= inFlight - 2'd1;
			end
			if (startWr) begin
				done <= 1'b0; // new start hides old result
			end else if (mulRsp.valid) begin
				done <= 1'b1;
			end
			if (mulRsp.valid) regP <= mulRsp.p;
			if (wrEn) begin
				bQ.valid <= 1'b1;
			end else if (axilReq.bready) begin
				bQ.valid <= 1'b0;
			end
			if (rdEn) begin
				rQ.valid <= 1'b1;
			end else if (axilReq.rready) begin
				rQ.valid <= 1'b0;
			end
		end
	end

	// response payload, held until the handshake
	always_ff @(posedge clk) begin
		if (wrEn) begin
			bQ.resp <= isMapped(axilReq.aw.addr) ? lauPkg::RESP_OKAY : lauPkg::RESP_SLVERR;
		end
		if (rdEn) begin
			rQ.data <= rdWord;
			rQ.resp <= isMapped(axilReq.ar.addr) ? lauPkg::RESP_OKAY : lauPkg::RESP_SLVERR;
		end
	end

	always_comb begin
		axilRsp.b = bQ;
		axilRsp.r = rQ;
		axilRsp.awready = wrEn;
		axilRsp.wready = wrEn;
		axilRsp.arready = rdEn;
		mulReq.valid = startQ;
		mulReq.x = regX; // already updated by the start write
		mulReq.y = regY;
	end

endmodule

`default_nettype wire

// ==== src/mulUns.sv ====
// two-stage unsigned brown-array multiplier, carry-save stage then prefix final adder
`timescale 1ns/1ps
`default_nettype none

module mulUns #(
	parameter int widthX = 16, // multiplier, <= widthY
	parameter int widthY = 24,
	parameter lauPkg::speedE speed = lauPkg::FAST
) (
	input wire logic clk,
	input wire logic rst,
	input wire lauPkg::mulReqT mulReq,
	output lauPkg::mulRspT mulRsp // 2 cycles after the request
);

	localparam int widthP = widthX + widthY;

	typedef struct packed {
		logic valid;
		logic [widthP-1:0] sum;
		logic [widthP-1:0] carry;
	} csvStageT;

	logic [widthX*widthP-1:0] pp; // partial product i at [i*widthP +: widthP]
	logic [widthP-1:0] csSum;
	logic [widthP-1:0] csCarry;
	logic [widthP-1:0] prod;
	csvStageT stage1; // carry-save result

	always_comb begin
		pp = '0;
		for (int i = 0; i < widthX; i++) begin
			for (int k = 0; k < widthY; k++) begin
				pp[i*widthP+i+k] = mulReq.x[i] & mulReq.y[k]; // row i shifted by i
			end
		end
	end

	mopCsvAdder #(
		.width(widthP),
		.depth(widthX),
		.speed(speed)
	) csv0 (
		.A(pp),
		.S(csSum),
		.C(csCarry)
	);

	always_ff @(posedge clk) begin
		if (mulReq.valid) begin // hold payload between requests
			stage1.sum <= csSum;
			stage1.carry <= csCarry;
		end
		if (rst) begin
			stage1.valid <= 1'b0;
		end else begin
			stage1.valid <= mulReq.valid;
		end
	end

	prefixAdder #(
		.width(widthP),
		.speed(speed)
	) cpa0 (
		.A(stage1.sum),
		.B(stage1.carry),
		.S(prod)
	);

	always_ff @(posedge clk) begin
		if (stage1.valid) begin
			mulRsp.p <= prod;
		end
		if (rst) begin
			mulRsp.valid <= 1'b0;
		end else begin
			mulRsp.valid <= stage1.valid;
		end
	end

endmodule

`default_nettype wire

// ==== src/prefixAdder.sv ====
// carry-propagate adder on the prefix network, serial chain when SLOW, sklansky tree when FAST
`timescale 1ns/1ps
`default_nettype none

module prefixAdder #(
	parameter int width = 8,
	parameter lauPkg::speedE speed = lauPkg::FAST
) (
	input wire logic [width-1:0] A,
	input wire logic [width-1:0] B,
	output logic [width-1:0] S // sum, carry out dropped
);

	logic [width-1:0] gen;
	logic [width-1:0] prop;
	logic [width-1:0] halfSum;
	logic [width-1:0] carryGen; // carry out of each bit position

	assign gen = A & B;
	assign prop = A | B; // or-propagate is enough for carries
	assign halfSum = A ^ B;

	prefixAndOr #(
		.width(width),
		.speed(speed) // serial ripple or sklansky levels
	) prefix0 (
		.GI(gen),
		.PI(prop),
		.GO(carryGen),
		.PO() // group propagate not needed, no carry in
	);

	assign S = halfSum ^ {carryGen[width-2:0], 1'b0}; // carry into bit i from bit i-1

endmodule

`default_nettype wire

// ==== src/prefixAndOr.sv ====
// generate/propagate prefix network, serial chain or sklansky tree, used by the final adder
`timescale 1ns/1ps
`default_nettype none

module prefixAndOr #(
	parameter int width = 8,
	parameter lauPkg::speedE speed = lauPkg::FAST
) (
	input wire logic [width-1:0] GI, // generate in
	input wire logic [width-1:0] PI, // propagate in
	output logic [width-1:0] GO, // group generate from bit 0
	output logic [width-1:0] PO // group propagate from bit 0
);

	localparam int n = width;
	localparam int m = $clog2(width); // tree depth

	if (speed == lauPkg::FAST) begin : gSklansky
		// level l lives in bits [l*n +: n], level 0 is the input
		logic [(m+1)*n-1:0] gTmp;
		logic [(m+1)*n-1:0] pTmp;

		assign gTmp[n-1:0] = GI;
		assign pTmp[n-1:0] = PI;

		for (genvar l = 1; l <= m; l++) begin : gLevel
			for (genvar k = 0; k < 2**(m-l); k++) begin : gGroup
				for (genvar i = 0; i < 2**(l-1); i++) begin : gBit
					localparam int lo = k*2**l + i; // lower half of group
					localparam int hi = lo + 2**(l-1); // upper half of group
					localparam int src = k*2**l + 2**(l-1) - 1; // top bit of lower half
					if (lo < n) begin : gPass
						assign gTmp[l*n+lo] = gTmp[(l-1)*n+lo];
						assign pTmp[l*n+lo] = pTmp[(l-1)*n+lo];
					end
					if (hi < n) begin : gComb
						// fan out lower-half result into each upper bit
						assign gTmp[l*n+hi] = gTmp[(l-1)*n+hi]
							| (pTmp[(l-1)*n+hi] & gTmp[(l-1)*n+src]);
						assign pTmp[l*n+hi] = pTmp[(l-1)*n+hi] & pTmp[(l-1)*n+src];
					end
				end
			end
		end

		assign GO = gTmp[m*n +: n]; // last level
		assign PO = pTmp[m*n +: n];
	end else begin : gSerial
		logic [n-1:0] gChain;
		logic [n-1:0] pChain;

		assign gChain[0] = GI[0];
		assign pChain[0] = PI[0];
		for (genvar i = 1; i < n; i++) begin : gBit
			assign gChain[i] = GI[i] | (PI[i] & gChain[i-1]); // ripple one bit
			assign pChain[i] = PI[i] & pChain[i-1];
		end

		assign GO = gChain;
		assign PO = pChain;
	end

endmodule

`default_nettype wire
